/* list.f */
verilog/pixel_pkg.sv
verilog/mem_write_if.sv
verilog/cmd_dispatch.sv
verilog/cmd_write_pixel.sv
verilog/cmd_clear.sv
verilog/frame_buffer.sv
verilog/pixel_cmd_top.sv
dv/pixel_cmd_tb.sv

/* Makefile */
TOP = pixel_cmd_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f list.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

/* dv/pixel_cmd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_cmd_tb;

    localparam int height = pixel_pkg::pixel_height;
    localparam int width = pixel_pkg::pixel_width;
    localparam int bpp = pixel_pkg::bytes_per_pixel;
    localparam int clear_cycles = height * width * bpp + 1;  // sweep plus final cycle.
    localparam int watchdog_cycles = 20 * clear_cycles + 2000;

    logic                           clk = 1'b0;
    logic                           reset = 1'b1;
    logic [7:0]                     in_data = 8'h00;
    logic                           in_valid = 1'b0;
    logic                           in_ready;
    logic [pixel_pkg::row_bits-1:0] rd_row = '0;
    logic [pixel_pkg::col_bits-1:0] rd_column = '0;
    logic [pixel_pkg::sel_bits-1:0] rd_sel = '0;
    logic [7:0]                     rd_data;
    logic                           cmd_done;
    logic                           cmd_error;

    logic [7:0] shadow [height][width][bpp];
    logic       rd_req = 1'b0;
    logic [7:0] rd_exp = 8'h00;
    logic       chk_req = 1'b0;
    logic [7:0] chk_exp = 8'h00;
    int         chk_row = 0;
    int         chk_col = 0;
    int         chk_sel = 0;
    int         seed = 61425;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         test_start_errors = 0;
    int         done_count = 0;
    int         err_count = 0;
    int         stall_count = 0;

    pixel_cmd_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .rd_row     (rd_row),
        .rd_column  (rd_column),
        .rd_sel     (rd_sel),
        .rd_data    (rd_data),
        .cmd_done   (cmd_done),
        .cmd_error  (cmd_error)
    );

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    function automatic int rand_below(input int n);
        int v;
        v = $random(seed) & 32'h7fff_ffff;
        return v % n;
    endfunction

    // colour byte k of a command lands at sel 2-k, so rgb[8s +: 8] is sel s.
    function automatic void apply_clear(input logic [23:0] rgb);
        for (int r = 0; r < height; r++) begin
            for (int c = 0; c < width; c++) begin
                for (int s = 0; s < bpp; s++) begin
                    shadow[r][c][s] = rgb[8*s +: 8];
                end
            end
        end
    endfunction

    function automatic void apply_write(input logic [7:0] row_byte, input int col,
                                        input logic [23:0] rgb);
        int row;
        row = int'(row_byte & 8'h1f);  // only the low 5 bits address a row.
        for (int s = 0; s < bpp; s++) begin
            shadow[row][col][s] = rgb[8*s +: 8];
        end
    endfunction

    function automatic logic [7:0] expected_byte(input int row, input int col, input int sel);
        return shadow[row][col][sel];
    endfunction

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        in_data = b;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);  // byte taken here.
        #1;
        in_valid = 1'b0;
        in_data = 8'h00;
    endtask

    task automatic send_write_pixel(input logic [7:0] row_byte, input int col,
                                    input logic [23:0] rgb, input int gap);
        logic [7:0] bytes [$];
        bytes.push_back(pixel_pkg::op_write_pixel);
        bytes.push_back(row_byte);
        for (int i = 0; i < pixel_pkg::col_bytes; i++) begin
            bytes.push_back(8'(col >> (8 * i)));  // little endian.
        end
        bytes.push_back(rgb[23:16]);
        bytes.push_back(rgb[15:8]);
        bytes.push_back(rgb[7:0]);
        foreach (bytes[i]) begin
            if (i > 0 && gap > 0) begin
                step(1 + rand_below(gap));
            end
            send_byte(bytes[i]);
        end
        apply_write(row_byte, col, rgb);
    endtask

    task automatic wait_done(input int start, input int max_cycles, output int latency);
        latency = 0;
        while (done_count == start && latency < max_cycles) begin
            step(1);
            latency++;
        end
        if (done_count == start) begin
            $display("no cmd_done seen within %0d cycles", max_cycles);
            errors++;
        end
    endtask

    task automatic write_and_wait(input logic [7:0] row_byte, input int col,
                                  input logic [23:0] rgb, input int gap);
        int start;
        int lat;
        start = done_count;
        send_write_pixel(row_byte, col, rgb, gap);
        wait_done(start, 10, lat);
        check("write pixel cmd_done latency", lat, 1);
    endtask

    task automatic clear_and_wait(input logic [23:0] rgb);
        int start;
        int lat;
        start = done_count;
        send_byte(pixel_pkg::op_clear);
        send_byte(rgb[23:16]);
        send_byte(rgb[15:8]);
        send_byte(rgb[7:0]);
        apply_clear(rgb);
        wait_done(start, clear_cycles + 10, lat);
        check("clear cmd_done latency", lat, clear_cycles);
    endtask

    task automatic read_pixel(input int row, input int col);
        if (row >= 0 && row < height && col >= 0 && col < width) begin
            for (int s = 0; s < bpp; s++) begin
                rd_row = (pixel_pkg::row_bits)'(row);
                rd_column = (pixel_pkg::col_bits)'(col);
                rd_sel = (pixel_pkg::sel_bits)'(s);
                rd_exp = expected_byte(row, col, s);
                rd_req = 1'b1;
                step(1);
            end
            rd_req = 1'b0;
        end
    endtask

    task automatic start_test();
        test_start_errors = errors;
    endtask

    task automatic finish_test(input string name);
        step(2);  // let the last readback compare.
        tests++;
        $display("test %0d %s: %s", tests, name,
                 (errors == test_start_errors) ? "passed" : "failed");
    endtask

    // read data is one cycle behind its address.
    always @(posedge clk) begin
        chk_req <= rd_req;
        chk_exp <= rd_exp;
        chk_row <= int'(rd_row);
        chk_col <= int'(rd_column);
        chk_sel <= int'(rd_sel);
    end

    always @(negedge clk) begin
        if (chk_req) begin
            check($sformatf("rd_data at row %0d column %0d sel %0d", chk_row, chk_col, chk_sel),
                  32'(rd_data), 32'(chk_exp));
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (cmd_done) done_count++;
            if (cmd_error) err_count++;
            if (!in_ready) stall_count++;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("simulation stopped by the watchdog after %0d cycles", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int d0;
        int e0;
        int s0;
        int rows [8];
        int cols [8];
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        step(2);

        start_test();
        d0 = done_count;
        s0 = stall_count;
        clear_and_wait(24'h123456);
        check("in_ready low cycles", stall_count - s0, clear_cycles);
        step(2);
        check("cmd_done pulses", done_count - d0, 1);
        for (int r = 0; r < height; r++) begin
            for (int c = 0; c < width; c++) begin
                if ((r + c) % 3 == 0) read_pixel(r, c);
            end
        end
        finish_test("clear and sampled readback");

        start_test();
        for (int i = 0; i < 8; i++) begin
            rows[i] = rand_below(height);
            cols[i] = rand_below(width);
            write_and_wait(8'(rows[i]), cols[i], 24'($random(seed)), 0);
        end
        for (int i = 0; i < 8; i++) begin
            read_pixel(rows[i], cols[i]);
            read_pixel(rows[i] - 1, cols[i]);
            read_pixel(rows[i] + 1, cols[i]);
            read_pixel(rows[i], cols[i] - 1);
            read_pixel(rows[i], cols[i] + 1);
        end
        finish_test("random pixel writes");

        start_test();
        write_and_wait(8'he5, 17, 24'ha1b2c3, 0);
        write_and_wait(8'h7f, 39, 24'h0f1e2d, 0);
        read_pixel(5, 17);
        read_pixel(31, 39);
        finish_test("row high bits ignored");

        start_test();
        d0 = done_count;
        e0 = err_count;
        send_byte(8'ha5);
        write_and_wait(8'd9, 23, 24'h5a6b7c, 0);
        step(2);
        check("cmd_error pulses", err_count - e0, 1);
        check("cmd_done pulses", done_count - d0, 1);
        read_pixel(9, 23);
        finish_test("unknown opcode dropped");

        start_test();
        d0 = done_count;
        write_and_wait(8'd20, 3, 24'hc0ffee, 4);
        send_write_pixel(8'd20, 4, 24'hc0ffee, 0);
        send_write_pixel(8'd21, 3, 24'hc0ffee, 0);
        step(3);
        check("cmd_done pulses", done_count - d0, 3);
        read_pixel(20, 3);
        read_pixel(20, 4);
        read_pixel(21, 3);
        finish_test("gaps and back to back commands");

        start_test();
        clear_and_wait(24'h0a0b0c);
        for (int r = 0; r < height; r++) begin
            for (int c = 0; c < width; c++) begin
                read_pixel(r, c);
            end
        end
        finish_test("clear over written pixels");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/pixel_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_cmd_top (
    input  wire                              clk,
    input  wire                              reset,
    input  wire [7:0]                        in_data,
    input  wire                              in_valid,
    output logic                             in_ready,
    input  wire [pixel_pkg::row_bits-1:0]    rd_row,
    input  wire [pixel_pkg::col_bits-1:0]    rd_column,
    input  wire [pixel_pkg::sel_bits-1:0]    rd_sel,
    output logic [7:0]                       rd_data,
    output logic                             cmd_done,
    output logic                             cmd_error
);

    logic [7:0] byte_data;
    logic       wp_take;
    logic       clr_take;
    logic       wp_done;
    logic       clr_done;
    logic       clr_busy;

    mem_write_if wp_wr ();
    mem_write_if clr_wr ();
    mem_write_if buf_wr ();

    cmd_dispatch dispatch_i (
        .clk        (clk),
        .reset      (reset),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .wp_done    (wp_done),
        .clr_done   (clr_done),
        .clr_busy   (clr_busy),
        .in_ready   (in_ready),
        .byte_data  (byte_data),
        .wp_take    (wp_take),
        .clr_take   (clr_take),
        .cmd_done   (cmd_done),
        .cmd_error  (cmd_error),
        .wp_wr      (wp_wr.buffer),
        .clr_wr     (clr_wr.buffer),
        .buf_wr     (buf_wr.writer)
    );

    cmd_write_pixel write_pixel_i (
        .clk        (clk),
        .reset      (reset),
        .byte_data  (byte_data),
        .take       (wp_take),
        .done       (wp_done),
        .wr         (wp_wr.writer)
    );

    cmd_clear clear_i (
        .clk        (clk),
        .reset      (reset),
        .byte_data  (byte_data),
        .take       (clr_take),
        .done       (clr_done),
        .busy       (clr_busy),
        .wr         (clr_wr.writer)
    );

    frame_buffer buffer_i (
        .clk        (clk),
        .reset      (reset),
        .rd_row     (rd_row),
        .rd_column  (rd_column),
        .rd_sel     (rd_sel),
        .rd_data    (rd_data),
        .wr         (buf_wr.buffer)
    );

endmodule

`default_nettype wire

/* verilog/frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
    input  wire                              clk,
    input  wire                              reset,
    input  wire [pixel_pkg::row_bits-1:0]    rd_row,
    input  wire [pixel_pkg::col_bits-1:0]    rd_column,
    input  wire [pixel_pkg::sel_bits-1:0]    rd_sel,
    output logic [7:0]                       rd_data,
    mem_write_if.buffer                      wr
);

    logic [7:0]                       mem [pixel_pkg::mem_bytes];
    logic [pixel_pkg::addr_bits-1:0]  wr_addr;
    logic [pixel_pkg::addr_bits-1:0]  rd_addr;

    // pixels are row major, three bytes each.
    function automatic logic [pixel_pkg::addr_bits-1:0] byte_addr(
        input logic [pixel_pkg::row_bits-1:0] row,
        input logic [pixel_pkg::col_bits-1:0] column,
        input logic [pixel_pkg::sel_bits-1:0] sel
    );
        int lin;
        lin = (int'(row) * pixel_pkg::pixel_width + int'(column)) *
              pixel_pkg::bytes_per_pixel + int'(sel);
        return (pixel_pkg::addr_bits)'(lin);
    endfunction

    assign wr_addr = byte_addr(wr.row, wr.column, wr.sel);
    assign rd_addr = byte_addr(rd_row, rd_column, rd_sel);

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr_addr] <= wr.data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data <= 8'd0;
        end else if (int'(rd_addr) < pixel_pkg::mem_bytes) begin
            rd_data <= mem[rd_addr];
        end else begin
            rd_data <= 8'd0;  // column past the display edge.
        end
    end

    a_wr_in_range: assert property (@(posedge clk) disable iff (reset)
        wr.we |-> (int'(wr.row) < pixel_pkg::pixel_height &&
                   int'(wr.column) < pixel_pkg::pixel_width));

endmodule

`default_nettype wire

/* verilog/cmd_clear.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_clear (
    input  wire              clk,
    input  wire              reset,
    input  wire [7:0]        byte_data,
    input  wire              take,
    output logic             done,
    output logic             busy,
    mem_write_if.writer      wr
);

    typedef enum logic [1:0] {
        st_color,
        st_sweep,
        st_final
    } clr_state_t;

    clr_state_t                        state;
    logic [7:0]                        color [pixel_pkg::bytes_per_pixel];
    logic [pixel_pkg::sel_bits-1:0]    cap_idx;
    logic [pixel_pkg::row_bits-1:0]    row_cnt;
    logic [pixel_pkg::col_bits-1:0]    col_cnt;
    logic [pixel_pkg::sel_bits-1:0]    sel_cnt;
    logic                              sel_last;
    logic                              col_last;
    logic                              row_last;

    assign busy = (state != st_color);
    assign sel_last = (sel_cnt == (pixel_pkg::sel_bits)'(pixel_pkg::bytes_per_pixel - 1));
    assign col_last = (col_cnt == (pixel_pkg::col_bits)'(pixel_pkg::pixel_width - 1));
    assign row_last = (row_cnt == (pixel_pkg::row_bits)'(pixel_pkg::pixel_height - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_color;
            cap_idx <= (pixel_pkg::sel_bits)'(pixel_pkg::bytes_per_pixel - 1);
            row_cnt <= '0;
            col_cnt <= '0;
            sel_cnt <= '0;
            wr.we <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_color: begin
                    wr.we <= 1'b0;
                    if (take) begin
                        cap_idx <= cap_idx - 1'b1;
                        if (cap_idx == '0) begin
                            cap_idx <= (pixel_pkg::sel_bits)'(pixel_pkg::bytes_per_pixel - 1);
                            state <= st_sweep;
                        end
                    end
                end
                st_sweep: begin
                    wr.we <= 1'b1;
                    sel_cnt <= sel_last ? '0 : sel_cnt + 1'b1;
                    if (sel_last) begin
                        col_cnt <= col_last ? '0 : col_cnt + 1'b1;
                        if (col_last) begin
                            row_cnt <= row_last ? '0 : row_cnt + 1'b1;
                            if (row_last) begin
                                done <= 1'b1;  // goes out with the final write.
                                state <= st_final;
                            end
                        end
                    end
                end
                default: begin
                    wr.we <= 1'b0;
                    state <= st_color;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_color && take) begin
            color[cap_idx] <= byte_data;  // first byte is red.
        end
        if (state == st_sweep) begin
            wr.row <= row_cnt;
            wr.column <= col_cnt;
            wr.sel <= sel_cnt;
            wr.data <= color[sel_cnt];
        end
    end

    a_no_take_busy: assert property (@(posedge clk) disable iff (reset)
        busy |-> !take);

endmodule

`default_nettype wire

/* verilog/cmd_write_pixel.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_write_pixel (
    input  wire              clk,
    input  wire              reset,
    input  wire [7:0]        byte_data,
    input  wire              take,
    output logic             done,
    mem_write_if.writer      wr
);

    typedef enum logic [1:0] {
        st_row,
        st_column,
        st_color
    } wp_state_t;

    wp_state_t                             state;
    logic [pixel_pkg::col_byte_bits-1:0]   col_idx;   // column byte in flight.
    logic [pixel_pkg::sel_bits-1:0]        sel_cnt;
    logic [pixel_pkg::row_bits-1:0]        row_q;
    logic [pixel_pkg::col_bits-1:0]        col_q;
    logic                                  col_last;

    assign col_last = (col_idx ==
        (pixel_pkg::col_byte_bits)'(pixel_pkg::col_bytes - 1));

    assign wr.row = row_q;
    assign wr.column = col_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_row;
            col_idx <= '0;
            sel_cnt <= '0;
            wr.we <= 1'b0;
            done <= 1'b0;
        end else begin
            wr.we <= 1'b0;
            done <= 1'b0;
            case (state)
                st_row: begin
                    if (take) begin
                        col_idx <= '0;
                        state <= st_column;
                    end
                end
                st_column: begin
                    if (take) begin
                        if (col_last) begin
                            sel_cnt <= (pixel_pkg::sel_bits)'(pixel_pkg::bytes_per_pixel - 1);
                            state <= st_color;
                        end else begin
                            col_idx <= col_idx + 1'b1;
                        end
                    end
                end
                st_color: begin
                    if (take) begin
                        wr.we <= 1'b1;  // one write per colour byte.
                        sel_cnt <= sel_cnt - 1'b1;
                        if (sel_cnt == '0) begin
                            done <= 1'b1;
                            state <= st_row;
                        end
                    end
                end
                default: state <= st_row;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            case (state)
                st_row: begin
                    row_q <= byte_data[pixel_pkg::row_bits-1:0];  // high bits ignored.
                end
                st_column: begin
                    // little endian, so byte n fills bits 8n and up.
                    for (int b = 0; b < pixel_pkg::col_bits; b++) begin
                        if (b / 8 == int'(col_idx)) begin
                            col_q[b] <= byte_data[b % 8];
                        end
                    end
                end
                st_color: begin
                    wr.sel <= sel_cnt;
                    wr.data <= byte_data;
                end
                default: ;
            endcase
        end
    end

    // only the final write of a command may fall outside the colour phase.
    a_we_in_color: assert property (@(posedge clk) disable iff (reset)
        wr.we |-> (state == st_color) || done);

endmodule

`default_nettype wire

/* verilog/cmd_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
    input  wire              clk,
    input  wire              reset,
    input  wire [7:0]        in_data,
    input  wire              in_valid,
    input  wire              wp_done,
    input  wire              clr_done,
    input  wire              clr_busy,
    output logic             in_ready,
    output logic [7:0]       byte_data,
    output logic             wp_take,
    output logic             clr_take,
    output logic             cmd_done,
    output logic             cmd_error,
    mem_write_if.buffer      wp_wr,
    mem_write_if.buffer      clr_wr,
    mem_write_if.writer      buf_wr
);

    pixel_pkg::cmd_kind_t state;
    pixel_pkg::cmd_kind_t cur_kind;
    logic                 accept;
    logic                 handler_done;
    logic                 use_clr;

    assign in_ready = !clr_busy;  // only a clear sweep stalls the host.
    assign accept = in_valid && in_ready;
    assign byte_data = in_data;

    assign handler_done = (state == pixel_pkg::kind_write_pixel && wp_done) ||
                          (state == pixel_pkg::kind_clear && clr_done);

    // a byte arriving with the done pulse is already the next opcode.
    assign cur_kind = handler_done ? pixel_pkg::kind_none : state;

    assign wp_take = accept && (cur_kind == pixel_pkg::kind_write_pixel);
    assign clr_take = accept && (cur_kind == pixel_pkg::kind_clear);
    assign cmd_done = handler_done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= pixel_pkg::kind_none;
            cmd_error <= 1'b0;
        end else begin
            cmd_error <= 1'b0;
            if (cur_kind == pixel_pkg::kind_none) begin
                state <= pixel_pkg::kind_none;
                if (accept) begin
                    case (in_data)
                        pixel_pkg::op_write_pixel: state <= pixel_pkg::kind_write_pixel;
                        pixel_pkg::op_clear:       state <= pixel_pkg::kind_clear;
                        default:                   cmd_error <= 1'b1;  // opcode dropped.
                    endcase
                end
            end
        end
    end

    // the last write of a command still lands while state holds the handler.
    assign use_clr = (state == pixel_pkg::kind_clear);

    assign buf_wr.we = use_clr ? clr_wr.we
                               : (state == pixel_pkg::kind_write_pixel) && wp_wr.we;
    assign buf_wr.row = use_clr ? clr_wr.row : wp_wr.row;
    assign buf_wr.column = use_clr ? clr_wr.column : wp_wr.column;
    assign buf_wr.sel = use_clr ? clr_wr.sel : wp_wr.sel;
    assign buf_wr.data = use_clr ? clr_wr.data : wp_wr.data;

    a_no_write_idle: assert property (@(posedge clk) disable iff (reset)
        (state == pixel_pkg::kind_none) |-> !(wp_wr.we || clr_wr.we));

    a_one_writer: assert property (@(posedge clk) disable iff (reset)
        $onehot0({wp_wr.we, clr_wr.we}));

endmodule

`default_nettype wire

/* verilog/mem_write_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_write_if;

    logic                             we;
    logic [pixel_pkg::row_bits-1:0]   row;
    logic [pixel_pkg::col_bits-1:0]   column;
    logic [pixel_pkg::sel_bits-1:0]   sel;     // colour byte index.
    logic [7:0]                       data;

    modport writer (
        output we, row, column, sel, data
    );

    modport buffer (
        input we, row, column, sel, data
    );

endinterface

`default_nettype wire

/* verilog/pixel_pkg.sv */
`default_nettype none

package pixel_pkg;

    // display geometry.
    localparam int pixel_width = 40;
    localparam int pixel_height = 32;
    localparam int bytes_per_pixel = 3;  // byte 2 red, 1 green, 0 blue.

    // derived widths.
    localparam int row_bits = $clog2(pixel_height);
    localparam int col_bits = $clog2(pixel_width);
    localparam int col_bytes = (col_bits + 7) / 8;  // little-endian bytes on the wire.
    localparam int col_byte_bits = (col_bytes > 1) ? $clog2(col_bytes) : 1;
    localparam int sel_bits = $clog2(bytes_per_pixel);

    localparam int mem_bytes = pixel_height * pixel_width * bytes_per_pixel;
    localparam int addr_bits = $clog2(mem_bytes);

    // command opcodes.
    localparam logic [7:0] op_write_pixel = 8'h01;
    localparam logic [7:0] op_clear = 8'h02;

    typedef enum logic [1:0] {
        kind_none,
        kind_write_pixel,
        kind_clear
    } cmd_kind_t;

endpackage

`default_nettype wire
